//--- build.f
hdl/armIsaPkg.sv
hdl/uopCtrlPkg.sv
hdl/instrClassifier.sv
hdl/condCheck.sv
hdl/ldmRegWalker.sv
hdl/uopSequencer.sv
hdl/uopFormatter.sv
hdl/microOpExpander.sv
verification/uopSequencer_assertions.sv
verification/microOpExpanderTb.sv

//--- hdl/armIsaPkg.sv
// ARM instruction set constants
package armIsaPkg;

	localparam int instrWidth = 32; // Full instruction word
	localparam int regIdxWidth = 4; // r0 to r15
	localparam int regListWidth = 16; // One bit per register in LDM

	localparam logic [regIdxWidth-1:0] regPc = 4'd15;
	localparam logic [regIdxWidth-1:0] regLr = 4'd14;
	localparam logic [regIdxWidth-1:0] regRz = 4'd15; // Scratch slot, remapped by regFileRz

	// Bits 27:6 of BX/BLX, which also look like RSR
	localparam logic [21:0] bxPattern = {8'b0001_0010, 12'hFFF, 2'b00};

	typedef enum logic [3:0] {
		condEq = 4'b0000, // Z set
		condNe = 4'b0001,
		condCs = 4'b0010, // C set
		condCc = 4'b0011,
		condMi = 4'b0100, // N set
		condPl = 4'b0101,
		condVs = 4'b0110, // V set
		condVc = 4'b0111,
		condHi = 4'b1000, // Unsigned higher
		condLs = 4'b1001,
		condGe = 4'b1010, // Signed compares
		condLt = 4'b1011,
		condGt = 4'b1100,
		condLe = 4'b1101,
		condAl = 4'b1110,
		condNv = 4'b1111  // Never
	} condCode;

	typedef enum logic [3:0] {
		opAnd = 4'b0000,
		opEor = 4'b0001,
		opSub = 4'b0010,
		opRsb = 4'b0011,
		opAdd = 4'b0100,
		opAdc = 4'b0101,
		opSbc = 4'b0110,
		opRsc = 4'b0111,
		opTst = 4'b1000,
		opTeq = 4'b1001,
		opCmp = 4'b1010,
		opCmn = 4'b1011,
		opOrr = 4'b1100,
		opMov = 4'b1101,
		opBic = 4'b1110,
		opMvn = 4'b1111
	} dpOpcode;

endpackage

//--- hdl/condCheck.sv
// Condition code evaluator
module condCheck import armIsaPkg::*; (
	input  logic [3:0] flags,
	input  condCode    cond,
	output logic       condPass
);

	logic n;
	logic z;
	logic c;
	logic v;

	assign n = flags[3]; // NZCV order
	assign z = flags[2];
	assign c = flags[1];
	assign v = flags[0];

	always_comb begin
		case (cond)
			condEq: condPass = z;
			condNe: condPass = !z;
			condCs: condPass = c;
			condCc: condPass = !c;
			condMi: condPass = n;
			condPl: condPass = !n;
			condVs: condPass = v;
			condVc: condPass = !v;
			condHi: condPass = c && !z;
			condLs: condPass = !c || z;
			condGe: condPass = (n == v);
			condLt: condPass = (n != v);
			condGt: condPass = !z && (n == v);
			condLe: condPass = z || (n != v);
			condAl: condPass = 1'b1;
			default: condPass = 1'b0; // NV never runs
		endcase
	end

endmodule

//--- hdl/instrClassifier.sv
// Instruction class decoder
module instrClassifier import armIsaPkg::*, uopCtrlPkg::*; (
	input  logic [instrWidth-1:0] defaultInstr,
	output instrClass             instClass
);

	logic isDataProc; // Bits 27:25 all zero
	logic isRegShift; // Shift amount from a register
	logic isBx; // Branch exchange shares the pattern
	logic isRsr;
	logic isBl;
	logic isLdm;

	assign isDataProc = (defaultInstr[27:25] == 3'b000);
	assign isRegShift = !defaultInstr[7] && defaultInstr[4]; // Bit 7 set would be multiply/extra load
	assign isBx = (defaultInstr[27:6] == bxPattern);

	assign isRsr = isDataProc && isRegShift && !isBx;
	assign isBl = (defaultInstr[27:24] == 4'b1011); // Link bit 24 set
	assign isLdm = (defaultInstr[27:25] == 3'b100) && defaultInstr[20]; // STM has L clear

	// Priority order matters only on paper, the patterns do not overlap
	always_comb begin
		if (isRsr) begin
			instClass = rsr;
		end else if (isBl) begin
			instClass = branchLink;
		end else if (isLdm) begin
			instClass = loadMultiple;
		end else begin
			instClass = plain; // Everything else, STM included
		end
	end

endmodule

//--- hdl/ldmRegWalker.sv
// Load multiple register walker
module ldmRegWalker import armIsaPkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   stallUop,
	input  logic                   atReady,
	input  logic [regListWidth-1:0] regList,
	input  logic [1:0]             puBits,
	output logic [regIdxWidth-1:0] loadReg,
	output logic [11:0]            startImm,
	output logic                   uBit,
	output logic                   lastReg
);

	localparam int countWidth = $clog2(regListWidth + 1);

	logic [regListWidth-1:0] storedList; // Registers still to load
	logic [regListWidth-1:0] curList;
	logic [regListWidth-1:0] remainList;
	logic [countWidth-1:0]   setCount;
	logic [11:0]             listBytes; // 4 x set bits

	// Fresh list from the instruction on the first micro-op
	assign curList = atReady ? regList : storedList;
	assign remainList = curList & (curList - 1'b1); // Drop lowest set bit

	always_ff @(posedge clk) begin
		if (reset) begin
			storedList <= '0;
		end else if (!stallUop) begin
			storedList <= remainList;
		end
	end

	// Lowest set bit wins, scanned from the top down
	always_comb begin
		loadReg = '0;
		for (int i = regListWidth - 1; i >= 0; i--) begin
			if (curList[i]) begin
				loadReg = regIdxWidth'(i);
			end
		end
	end

	assign setCount = countWidth'($countones(curList));
	assign lastReg = (setCount == countWidth'(1));
	assign listBytes = 12'(setCount) << 2;

	// Start offset relative to Rn per P/U addressing mode
	always_comb begin
		startImm = '0;
		uBit = 1'b1;
		case (puBits)
			2'b00: begin // DA, Rn - 4N + 4
				startImm = listBytes - 12'd4;
				uBit = 1'b0;
			end
			2'b01: begin // IA, start at Rn
				startImm = '0;
				uBit = 1'b1;
			end
			2'b10: begin // DB, Rn - 4N
				startImm = listBytes;
				uBit = 1'b0;
			end
			2'b11: begin // IB, Rn + 4
				startImm = 12'd4;
				uBit = 1'b1;
			end
			default: begin
				startImm = '0;
				uBit = 1'b1;
			end
		endcase
	end

endmodule

//--- hdl/microOpExpander.sv
// Micro-op expander top
module microOpExpander import armIsaPkg::*, uopCtrlPkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [instrWidth-1:0] defaultInstr,
	input  logic [3:0]            flags, // NZCV
	input  logic                  stallUop,
	output logic [instrWidth-1:0] uopInstr,
	output logic                  instrMux,
	output logic                  doNotUpdateFlag,
	output logic                  uopStall,
	output rzOverride             regFileRz,
	output logic                  prevRsrState,
	output logic                  ldmForward
);

	instrClass              instClass;
	logic                   condPass;
	logic                   atReady;
	logic [regIdxWidth-1:0] loadReg;
	logic [11:0]            startImm;
	logic                   uBit;
	logic                   lastReg;
	uopKind                 kind;

	instrClassifier classifier_i (
		.defaultInstr(defaultInstr),
		.instClass(instClass)
	);

	condCheck condCheck_i (
		.flags(flags),
		.cond(condCode'(defaultInstr[31:28])),
		.condPass(condPass)
	);

	ldmRegWalker walker_i (
		.clk(clk),
		.reset(reset),
		.stallUop(stallUop),
		.atReady(atReady),
		.regList(defaultInstr[regListWidth-1:0]),
		.puBits(defaultInstr[24:23]), // Addressing mode
		.loadReg(loadReg),
		.startImm(startImm),
		.uBit(uBit),
		.lastReg(lastReg)
	);

	uopSequencer sequencer_i (
		.clk(clk),
		.reset(reset),
		.stallUop(stallUop),
		.instClass(instClass),
		.condPass(condPass),
		.lastReg(lastReg),
		.atReady(atReady),
		.kind(kind),
		.instrMux(instrMux),
		.doNotUpdateFlag(doNotUpdateFlag),
		.uopStall(uopStall),
		.prevRsrState(prevRsrState),
		.ldmForward(ldmForward),
		.regFileRz(regFileRz)
	);

	uopFormatter formatter_i (
		.defaultInstr(defaultInstr),
		.kind(kind),
		.loadReg(loadReg),
		.startImm(startImm),
		.uBit(uBit),
		.uopInstr(uopInstr)
	);

endmodule

//--- hdl/uopCtrlPkg.sv
// Micro-op control types
package uopCtrlPkg;

	// Expansion class of the decode-stage word
	typedef enum logic [1:0] {
		plain,
		rsr, // Register-shifted-register data processing
		branchLink,
		loadMultiple
	} instrClass;

	typedef enum logic [1:0] {
		ready, // Idle, looking at a fresh instruction
		rsrSecond,
		blSecond,
		ldmRun // Walking the rest of the register list
	} seqState;

	typedef enum logic [2:0] {
		passThrough,
		rsrShift, // Rz = Rm shifted by Rs
		rsrOperate, // Rd = Rn op Rz
		blLink, // LR = PC
		blBranch,
		ldmFirst, // Load with start offset off Rn
		ldmNext, // Load at Rz + 4
		ldmFlush // Never-execute filler
	} uopKind;

	typedef logic [3:0] rzOverride; // {RA1 mux, WA3, RA2, RA1} Rz selects

	localparam rzOverride rzNone = 4'b0000;
	localparam rzOverride rzShiftDest = 4'b1100; // Write Rz, read Rm through first port
	localparam rzOverride rzOperandSrc = 4'b0010; // Read Rz on second port

endpackage

//--- hdl/uopFormatter.sv
// Micro-op word builder
module uopFormatter import armIsaPkg::*, uopCtrlPkg::*; (
	input  logic [instrWidth-1:0]  defaultInstr,
	input  uopKind                 kind,
	input  logic [regIdxWidth-1:0] loadReg,
	input  logic [11:0]            startImm,
	input  logic                   uBit,
	output logic [instrWidth-1:0]  uopInstr
);

	logic [3:0]  cond;
	logic        lBit;
	logic [3:0]  rn;
	logic [11:0] shifterOp;

	assign cond = defaultInstr[31:28];
	assign lBit = defaultInstr[20]; // Load/store direction
	assign rn = defaultInstr[19:16];
	assign shifterOp = defaultInstr[11:0];

	always_comb begin
		case (kind)
			rsrShift: begin // MOV Rz, Rm <shift> Rs
				uopInstr = {defaultInstr[31:25], opMov, 1'b0, 4'b0000, regRz, shifterOp};
			end
			rsrOperate: begin // Same op, Rz unshifted as operand 2
				uopInstr = {defaultInstr[31:12], 8'b0, regRz};
			end
			blLink: begin // MOV LR, PC
				uopInstr = {cond, 3'b000, opMov, 1'b0, 4'b0000, regLr, 8'b0, regPc};
			end
			blBranch: begin
				uopInstr = {defaultInstr[31:25], 1'b0, defaultInstr[23:0]}; // Link bit cleared
			end
			ldmFirst: begin // Pre-indexed immediate, no writeback
				uopInstr = {
					cond, 3'b010,
					1'b1, uBit, 1'b0, 1'b0, lBit, // P U B W L
					rn, loadReg,
					startImm
				};
			end
			ldmNext: begin // Register offset off forwarded Rz
				uopInstr = {
					cond, 3'b011,
					1'b1, 1'b1, 1'b0, 1'b0, lBit,
					regRz, loadReg,
					12'h00F // Rm slot reads the constant 4
				};
			end
			ldmFlush: begin
				uopInstr = {cond, 3'b001, opAdd, 1'b0, 20'b0}; // ADD r0, r0, #0 squashed
			end
			default: begin
				uopInstr = defaultInstr;
			end
		endcase
	end

endmodule

//--- hdl/uopSequencer.sv
// Micro-op sequencing FSM
module uopSequencer import uopCtrlPkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      stallUop,
	input  instrClass instClass,
	input  logic      condPass,
	input  logic      lastReg,
	output logic      atReady,
	output uopKind    kind,
	output logic      instrMux,
	output logic      doNotUpdateFlag,
	output logic      uopStall,
	output logic      prevRsrState,
	output logic      ldmForward,
	output rzOverride regFileRz
);

	seqState state;
	seqState nextState;

	// Back-pressure freezes the sequence where it is
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ready;
		end else if (!stallUop) begin
			state <= nextState;
		end
	end

	assign atReady = (state == ready);

	// Mealy decode of kind and next state
	always_comb begin
		nextState = state;
		kind = passThrough;
		case (state)
			ready: begin
				case (instClass)
					rsr: begin
						kind = rsrShift;
						nextState = rsrSecond;
					end
					branchLink: begin
						kind = blLink;
						nextState = blSecond;
					end
					loadMultiple: begin
						kind = ldmFirst;
						nextState = lastReg ? ready : ldmRun; // Single register is done at once
					end
					default: begin
						kind = passThrough;
						nextState = ready;
					end
				endcase
			end
			rsrSecond: begin
				kind = rsrOperate;
				nextState = ready;
			end
			blSecond: begin
				kind = blBranch;
				nextState = ready;
			end
			ldmRun: begin
				if (!condPass) begin
					kind = ldmFlush; // First load was skipped, abandon the rest
					nextState = ready;
				end else begin
					kind = ldmNext;
					nextState = lastReg ? ready : ldmRun;
				end
			end
			default: begin
				kind = passThrough;
				nextState = ready;
			end
		endcase
	end

	// Fetch holds the instruction until the final micro-op
	assign uopStall = (nextState != ready);

	assign instrMux = !(kind inside {passThrough, ldmFlush});
	assign doNotUpdateFlag = kind inside {rsrShift, ldmFirst, ldmNext, ldmFlush};
	assign prevRsrState = (kind == rsrOperate); // Operate stage reads shifter carry
	assign ldmForward = (kind == ldmNext); // Rz follows the previous address

	always_comb begin
		case (kind)
			rsrShift: regFileRz = rzShiftDest;
			rsrOperate: regFileRz = rzOperandSrc;
			default: regFileRz = rzNone;
		endcase
	end

endmodule

//--- verification/microOpExpanderTb.sv
// Micro-op expander testbench
module microOpExpanderTb import armIsaPkg::*; ();

	logic                  clk;
	logic                  reset;
	logic [instrWidth-1:0] defaultInstr;
	logic [3:0]            flags; // NZCV
	logic                  stallUop;
	logic [instrWidth-1:0] uopInstr;
	logic                  instrMux;
	logic                  doNotUpdateFlag;
	logic                  uopStall;
	logic [3:0]            regFileRz;
	logic                  prevRsrState;
	logic                  ldmForward;
	integer                seed; // Random register lists

	microOpExpander dut_i (
		.clk(clk),
		.reset(reset),
		.defaultInstr(defaultInstr),
		.flags(flags),
		.stallUop(stallUop),
		.uopInstr(uopInstr),
		.instrMux(instrMux),
		.doNotUpdateFlag(doNotUpdateFlag),
		.uopStall(uopStall),
		.regFileRz(regFileRz),
		.prevRsrState(prevRsrState),
		.ldmForward(ldmForward)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Overall run limit
	initial begin
		#1000000;
		$display("Run did not finish within the time limit");
		stopWithFailure();
	end

	task automatic stopWithFailure();
		$display("Simulation FAILED");
		$fatal(1, "Stopping on first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
			stopWithFailure();
		end
	endtask

	task automatic checkControls(input logic mux, input logic dnu, input logic stall,
		input logic [3:0] rz, input logic prsr, input logic fwd);
		checkValue("instrMux", instrMux, mux);
		checkValue("doNotUpdateFlag", doNotUpdateFlag, dnu);
		checkValue("uopStall", uopStall, stall);
		checkValue("regFileRz", regFileRz, rz);
		checkValue("prevRsrState", prevRsrState, prsr);
		checkValue("ldmForward", ldmForward, fwd);
	endtask

	// New word on the rising edge, outputs sampled at the falling edge
	task automatic applyWord(input logic [31:0] instr);
		@(posedge clk);
		defaultInstr <= instr;
		@(negedge clk);
	endtask

	task automatic nextCycle();
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic setStall(input logic value);
		@(posedge clk);
		stallUop <= value;
		@(negedge clk);
	endtask

	// Expected micro-op words, Rz is r15 and LR is r14
	function automatic logic [31:0] shiftWord(input logic [31:0] instr);
		return {instr[31:25], 4'b1101, 1'b0, 4'd0, 4'd15, instr[11:0]}; // MOV Rz
	endfunction

	function automatic logic [31:0] operateWord(input logic [31:0] instr);
		return {instr[31:12], 8'd0, 4'd15};
	endfunction

	function automatic logic [31:0] linkWord(input logic [31:0] instr);
		return {instr[31:28], 3'b000, 4'b1101, 1'b0, 4'd0, 4'd14, 8'd0, 4'd15}; // MOV LR, PC
	endfunction

	function automatic logic [31:0] branchWord(input logic [31:0] instr);
		return {instr[31:25], 1'b0, instr[23:0]};
	endfunction

	function automatic logic [31:0] firstLoadWord(input logic [31:0] instr,
		input logic [3:0] rd, input logic [11:0] imm, input logic up);
		return {instr[31:28], 3'b010, 1'b1, up, 2'b00, instr[20], instr[19:16], rd, imm};
	endfunction

	function automatic logic [31:0] nextLoadWord(input logic [31:0] instr, input logic [3:0] rd);
		return {instr[31:28], 3'b011, 2'b11, 2'b00, instr[20], 4'd15, rd, 12'h00F};
	endfunction

	function automatic logic [31:0] flushWord(input logic [31:0] instr);
		return {instr[31:28], 3'b001, 4'b0100, 1'b0, 20'd0}; // ADD with zero fields
	endfunction

	task automatic testPassThrough();
		logic [31:0] instr;
		instr = 32'hE0812003; // ADD r2, r1, r3, immediate shift
		applyWord(instr);
		checkValue("uopInstr", uopInstr, instr);
		checkControls(1'b0, 1'b0, 1'b0, 4'b0000, 1'b0, 1'b0);
		nextCycle();
		checkValue("uopInstr", uopInstr, instr); // Still in ready
	endtask

	task automatic testRsr();
		logic [31:0] instr;
		instr = 32'hE0812314; // ADD r2, r1, r4, LSL r3
		applyWord(instr);
		checkValue("uopInstr", uopInstr, shiftWord(instr));
		checkControls(1'b1, 1'b1, 1'b1, 4'b1100, 1'b0, 1'b0);
		nextCycle();
		checkValue("uopInstr", uopInstr, operateWord(instr));
		checkControls(1'b1, 1'b0, 1'b0, 4'b0010, 1'b1, 1'b0);
	endtask

	task automatic testBranchLink();
		logic [31:0] instr;
		instr = 32'hEB000010;
		applyWord(instr);
		checkValue("uopInstr", uopInstr, linkWord(instr));
		checkControls(1'b1, 1'b0, 1'b1, 4'b0000, 1'b0, 1'b0);
		nextCycle();
		checkValue("uopInstr", uopInstr, branchWord(instr));
		checkControls(1'b1, 1'b0, 1'b0, 4'b0000, 1'b0, 1'b0);
	endtask

	task automatic walkLoadMultiple(input logic [1:0] mode, input logic [15:0] list);
		logic [31:0] instr;
		logic [11:0] imm;
		logic        up;
		logic [3:0]  regs[$]; // Set bits, ascending
		int          count;
		int          step;
		for (int i = 0; i < 16; i++) begin
			if (list[i]) begin
				regs.push_back(4'(i));
			end
		end
		count = regs.size();
		case (mode)
			2'b00: imm = 12'(4 * (count - 1)); // DA
			2'b01: imm = 12'd0; // IA
			2'b10: imm = 12'(4 * count); // DB
			default: imm = 12'd4; // IB
		endcase
		up = mode[0];
		instr = {4'hE, 3'b100, mode, 2'b00, 1'b1, 4'd9, list}; // LDM r9, {list}
		applyWord(instr);
		step = 0;
		forever begin
			if (step == 0) begin
				checkValue("uopInstr", uopInstr, firstLoadWord(instr, regs[0], imm, up));
			end else begin
				checkValue("uopInstr", uopInstr, nextLoadWord(instr, regs[step]));
			end
			checkControls(1'b1, 1'b1, step != count - 1, 4'b0000, 1'b0, step != 0);
			if (!uopStall) begin
				break;
			end
			step++;
			if (step >= count) begin
				$display("Load multiple still stalling after %0d micro-ops", count);
				stopWithFailure();
			end
			nextCycle();
		end
	endtask

	task automatic testLoadMultiple();
		logic [15:0] list;
		for (int mode = 0; mode < 4; mode++) begin
			walkLoadMultiple(2'(mode), 16'h0001 << (mode * 5)); // Single register
			repeat (3) begin
				list = 16'($random(seed));
				if (list == 16'd0) begin
					list = 16'h8000;
				end
				walkLoadMultiple(2'(mode), list);
			end
		end
	endtask

	task automatic testCondFail();
		logic [31:0] instr;
		instr = {4'h0, 3'b100, 2'b01, 2'b00, 1'b1, 4'd3, 16'h0094}; // LDMEQ r3, {r2, r4, r7}
		@(posedge clk);
		flags <= 4'b0100; // Z set, EQ passes
		defaultInstr <= instr;
		@(negedge clk);
		checkValue("uopInstr", uopInstr, firstLoadWord(instr, 4'd2, 12'd0, 1'b1));
		checkControls(1'b1, 1'b1, 1'b1, 4'b0000, 1'b0, 1'b0);
		@(posedge clk);
		flags <= 4'b0000; // EQ now fails
		@(negedge clk);
		checkValue("uopInstr", uopInstr, flushWord(instr));
		checkControls(1'b0, 1'b1, 1'b0, 4'b0000, 1'b0, 1'b0);
		applyWord(32'hE1A00000);
		checkValue("uopInstr", uopInstr, 32'hE1A00000);
		checkControls(1'b0, 1'b0, 1'b0, 4'b0000, 1'b0, 1'b0);
	endtask

	task automatic testStall();
		logic [31:0] instr;
		logic [31:0] heldWord;
		instr = {4'hE, 3'b100, 2'b11, 2'b00, 1'b1, 4'd5, 16'h0C21}; // IB {r0, r5, r10, r11}
		heldWord = nextLoadWord(instr, 4'd5); // Second micro-op, repeated while stalled
		applyWord(instr);
		checkValue("uopInstr", uopInstr, firstLoadWord(instr, 4'd0, 12'd4, 1'b1));
		setStall(1'b1); // This edge still advances
		checkValue("uopInstr", uopInstr, heldWord);
		checkControls(1'b1, 1'b1, 1'b1, 4'b0000, 1'b0, 1'b1);
		repeat (3) begin
			nextCycle();
			checkValue("uopInstr", uopInstr, heldWord);
			checkControls(1'b1, 1'b1, 1'b1, 4'b0000, 1'b0, 1'b1);
		end
		setStall(1'b0); // Edge sees the old stall, word held once more
		checkValue("uopInstr", uopInstr, heldWord);
		nextCycle();
		checkValue("uopInstr", uopInstr, nextLoadWord(instr, 4'd10));
		checkControls(1'b1, 1'b1, 1'b1, 4'b0000, 1'b0, 1'b1);
		nextCycle();
		checkValue("uopInstr", uopInstr, nextLoadWord(instr, 4'd11));
		checkControls(1'b1, 1'b1, 1'b0, 4'b0000, 1'b0, 1'b1);
	endtask

	initial begin
		seed = 32'h02dbe571;
		reset = 1'b1;
		defaultInstr = 32'hE1A00000; // MOV r0, r0
		flags = 4'b0000;
		stallUop = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		testPassThrough();
		testRsr();
		testBranchLink();
		testLoadMultiple();
		testCondFail();
		testStall();
		if (dut_i.sequencer_i.seqChecks_i.failCount != 0) begin
			$display("Sequencer assertions fired during the run");
			stopWithFailure();
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

//--- verification/uopSequencer_assertions.sv
// Sequencer assertions
module uopSequencer_assertions import uopCtrlPkg::*; (
	input logic      clk,
	input logic      reset,
	input logic      stallUop,
	input instrClass instClass,
	input seqState   state,
	input logic      uopStall,
	input logic      instrMux,
	input logic      ldmForward
);

	int failCount = 0; // Assertion failures so far

	// A plain word in ready never holds fetch
	noStallOnPlain: assert property (@(posedge clk) disable iff (reset)
		(state == ready && instClass == plain) |-> !uopStall)
	else begin
		failCount++;
		$error("uopStall high for a plain word in ready");
	end

	stateHeldOnStall: assert property (@(posedge clk) disable iff (reset)
		stallUop |=> $stable(state))
	else begin
		failCount++; // Back-pressure must freeze the FSM
		$error("State moved across a stalled edge");
	end

	forwardNeedsMux: assert property (@(posedge clk) disable iff (reset)
		ldmForward |-> instrMux)
	else begin
		failCount++;
		$error("ldmForward high with instrMux low");
	end

endmodule

bind uopSequencer uopSequencer_assertions seqChecks_i (
	.clk(clk),
	.reset(reset),
	.stallUop(stallUop),
	.instClass(instClass),
	.state(state),
	.uopStall(uopStall),
	.instrMux(instrMux),
	.ldmForward(ldmForward)
);
